// File: flist.f
verilog/qspi_pkg.sv
verilog/sync_3stage.sv
verilog/qspi_device_if.sv
verilog/qspi_scratch_regs.sv
verilog/qspi_target_top.sv
test/qspi_target_properties.sv
test/tb_qspi_target.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_qspi_target
FLIST      := flist.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert --timescale 1ns/10ps
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# Exit status follows the search for the pass message
run: build
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_qspi_target.sv
`timescale 1ns/10ps

module tb_qspi_target;

	import qspi_pkg::*;

	localparam int CLK_HALF_NS   = 20;		// 40 ns clk period
	localparam int RESET_CYCLES  = 4;
	localparam int HALF_CLKS     = 4;		// clk cycles per SCK half-period
	localparam int RELEASE_LIMIT = 5;		// cs_n rise to bus released
	localparam int IDLE_CLKS     = 8;		// Gap between transactions
	localparam int SEED          = 32958;

	logic    clk;
	logic    rst_n;
	logic    sck;
	logic    cs_n;
	nibble_t dq_in;
	nibble_t dq_out;
	nibble_t dq_oe;

	byte_t model [REG_DEPTH];		// Expected bank contents
	bit    verdict_given;

	qspi_target_top dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.sck    (sck),
		.cs_n   (cs_n),
		.dq_in  (dq_in),
		.dq_out (dq_out),
		.dq_oe  (dq_oe)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF_NS clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Checking

	task automatic stop_on_failure();
		verdict_given = 1'b1;
		$display("Regression failed");
		$fatal(1, "Stopped at the first failing check");
	endtask

	task automatic check_byte(input string test_name, input byte_t expected,
			input byte_t actual);
		assert (actual === expected) else begin
			$display("** Error [%s] expected %02h, actual %02h", test_name, expected, actual);
			stop_on_failure();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// QSPI host model

	// Fall and drive, rise, then sample in the middle of the high phase
	task automatic clock_beat(input nibble_t drive_nib, output nibble_t rx_nib,
			output nibble_t oe_nib);
		@(posedge clk);
		sck   <= 1'b0;
		dq_in <= drive_nib;
		repeat (HALF_CLKS - 1) @(posedge clk);
		@(posedge clk);
		sck <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rx_nib = dq_out;		// Target output lags its SCK fall by 4 clk
		oe_nib = dq_oe;
		@(posedge clk);
	endtask

	task automatic select_target();
		@(posedge clk);
		cs_n <= 1'b0;
		repeat (HALF_CLKS - 1) @(posedge clk);	// Let CS# fall settle first
	endtask

	task automatic wait_bus_release(input string test_name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (dq_oe != 4'h0) begin
			cycles++;
			if (cycles > RELEASE_LIMIT) begin
				$display("** Error [%s] dq_oe still driven %0d cycles after deselect",
					test_name, cycles);
				stop_on_failure();
			end
			@(negedge clk);
		end
	endtask

	task automatic hold_idle(input string test_name);
		repeat (IDLE_CLKS) begin
			@(negedge clk);
			check_byte({test_name, "/idle_oe"}, 8'h00, byte_t'(dq_oe));
		end
	endtask

	// SCK low first, so the last edge is seen before CS# rises
	task automatic finish_transaction(input string test_name);
		@(posedge clk);
		sck <= 1'b0;
		repeat (HALF_CLKS - 1) @(posedge clk);
		@(posedge clk);
		cs_n  <= 1'b1;
		dq_in <= 4'h0;
		wait_bus_release(test_name);
		hold_idle(test_name);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Transactions

	task automatic write_transfer(input opcode_t op, input reg_addr_t addr, input int count,
			input string test_name);
		nibble_t   rx;
		nibble_t   oe;
		byte_t     data;
		reg_addr_t ptr;
		select_target();
		clock_beat(op, rx, oe);
		check_byte({test_name, "/oe"}, 8'h00, byte_t'(oe));
		clock_beat(addr, rx, oe);
		check_byte({test_name, "/oe"}, 8'h00, byte_t'(oe));
		clock_beat(4'h0, rx, oe);		// Dummy edge
		check_byte({test_name, "/oe"}, 8'h00, byte_t'(oe));
		ptr = addr;
		for (int i = 0; i < count; i++) begin
			data = byte_t'($urandom);
			clock_beat(data[7:4], rx, oe);
			check_byte({test_name, "/oe"}, 8'h00, byte_t'(oe));
			clock_beat(data[3:0], rx, oe);
			check_byte({test_name, "/oe"}, 8'h00, byte_t'(oe));
			if (op == OP_WRITE)
				model[ptr] = data;	// Other opcodes drop the data
			ptr = ptr + 4'd1;		// Wraps at REG_DEPTH
		end
		finish_transaction(test_name);
	endtask

	task automatic read_transfer(input reg_addr_t addr, input int count,
			input string test_name);
		nibble_t   hi;
		nibble_t   lo;
		nibble_t   oe;
		reg_addr_t ptr;
		select_target();
		clock_beat(OP_READ, hi, oe);
		check_byte({test_name, "/oe"}, 8'h00, byte_t'(oe));
		clock_beat(addr, hi, oe);
		check_byte({test_name, "/oe"}, 8'h00, byte_t'(oe));
		ptr = addr;
		for (int i = 0; i < count; i++) begin
			clock_beat(4'h0, hi, oe);
			check_byte({test_name, "/oe"}, 8'h0f, byte_t'(oe));	// Target owns the bus
			clock_beat(4'h0, lo, oe);
			check_byte({test_name, "/oe"}, 8'h0f, byte_t'(oe));
			check_byte(test_name, model[ptr], {hi, lo});
			ptr = ptr + 4'd1;
		end
		finish_transaction(test_name);
	endtask

	// One and a half bytes, then CS# rises with SCK still high
	task automatic aborted_read(input reg_addr_t addr, input string test_name);
		nibble_t hi;
		nibble_t lo;
		nibble_t oe;
		select_target();
		clock_beat(OP_READ, hi, oe);
		clock_beat(addr, hi, oe);
		clock_beat(4'h0, hi, oe);
		clock_beat(4'h0, lo, oe);
		check_byte(test_name, model[addr], {hi, lo});
		clock_beat(4'h0, hi, oe);
		check_byte({test_name, "/oe"}, 8'h0f, byte_t'(oe));
		@(posedge clk);
		cs_n <= 1'b1;
		wait_bus_release(test_name);
		@(posedge clk);
		sck <= 1'b0;
		hold_idle(test_name);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		reg_addr_t start;
		int        count;
		rst_n         = 1'b0;
		sck           = 1'b0;
		cs_n          = 1'b1;
		dq_in         = 4'h0;
		verdict_given = 1'b0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		hold_idle("reset_idle");

		// Whole bank written once, later reads never hit unwritten bytes
		start = reg_addr_t'($urandom_range(0, REG_DEPTH - 1));
		write_transfer(OP_WRITE, start, REG_DEPTH, "bank_fill");
		read_transfer(start, REG_DEPTH, "bank_fill");

		for (int n = 0; n < 4; n++) begin
			start = reg_addr_t'($urandom_range(0, REG_DEPTH - 1));
			count = $urandom_range(1, 6);
			write_transfer(OP_WRITE, start, count, "write_read");
			read_transfer(start, count, "write_read");
		end

		write_transfer(OP_WRITE, 4'd14, 4, "pointer_wrap");		// Lands on 14, 15, 0, 1
		read_transfer(4'd14, 4, "pointer_wrap");
		read_transfer(4'd0, 2, "pointer_wrap");

		start = reg_addr_t'($urandom_range(0, REG_DEPTH - 1));
		write_transfer(4'h7, start, 4, "unknown_opcode");
		read_transfer(4'd0, REG_DEPTH, "unknown_opcode");

		start = reg_addr_t'($urandom_range(0, REG_DEPTH - 1));
		aborted_read(start, "deselect_abort");
		read_transfer(start, 4, "deselect_abort");	// Fresh instruction after abort

		verdict_given = 1'b1;
		$display("Regression passed");
		$finish;
	end

	// Run ended without reaching a verdict
	final begin
		if (!verdict_given)
			$display("Regression failed");
	end

endmodule

// File: test/qspi_target_properties.sv
`timescale 1ns/10ps

module qspi_target_properties (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  cs_n,			// Raw pin, before the synchronizer
	input qspi_pkg::nibble_t     dq_oe,
	input logic                  insn_valid,
	input logic                  wr_valid,
	input logic                  rd_ready,
	input logic                  rd_sel,		// rd_mode captured with the instruction
	input qspi_pkg::qspi_state_t state
);

	import qspi_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Bus ownership

	// One enable for all four lanes
	a_oe_uniform: assert property (@(posedge clk) disable iff (!rst_n)
		(dq_oe == 4'h0) || (dq_oe == 4'hf))
		else $error("dq_oe has mixed lanes: %h", dq_oe);

	// Pin high for five samples, bus must be free by now
	a_oe_release: assert property (@(posedge clk) disable iff (!rst_n)
		(cs_n && $past(cs_n, 1) && $past(cs_n, 2) && $past(cs_n, 3) && $past(cs_n, 4))
		|-> (dq_oe == 4'h0))
		else $error("dq_oe still driven 5 cycles after cs_n rose");

	// Writes and unknown opcodes never turn the bus around
	a_oe_write_only: assert property (@(posedge clk) disable iff (!rst_n)
		!rd_sel |-> (dq_oe == 4'h0))
		else $error("dq_oe driven in a transaction that is not a read");

	//////////////////////////////////////////////////////////////////////
	// Strobes toward the register bank

	a_insn_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		insn_valid |=> !insn_valid)
		else $error("insn_valid high for more than one cycle");

	a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		wr_valid |=> !wr_valid)
		else $error("wr_valid high for more than one cycle");

	a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rd_ready |=> !rd_ready)
		else $error("rd_ready high for more than one cycle");

	// No write strobe while the target owns the bus
	a_no_wr_in_read: assert property (@(posedge clk) disable iff (!rst_n)
		wr_valid |-> ((state != RD_HI) && (state != RD_LO)))
		else $error("wr_valid seen in read state %0d", state);

endmodule

bind qspi_device_if qspi_target_properties u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.cs_n       (cs_n),
	.dq_oe      (dq_oe),
	.insn_valid (insn_valid),
	.wr_valid   (wr_valid),
	.rd_ready   (rd_ready),
	.rd_sel     (rd_sel),
	.state      (state)
);

// File: verilog/qspi_target_top.sv
`timescale 1ns/10ps

module qspi_target_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sck,
	input  logic              cs_n,
	input  qspi_pkg::nibble_t dq_in,	// From the external pad cell
	output qspi_pkg::nibble_t dq_out,	// To the external pad cell
	output qspi_pkg::nibble_t dq_oe		// All ones while driving
);

	import qspi_pkg::*;

	// Transceiver to bank
	logic  insn_valid;
	byte_t insn;
	logic  rd_mode;
	logic  wr_valid;
	byte_t wr_data;
	logic  rd_ready;
	logic  rd_valid;
	byte_t rd_data;

	qspi_device_if u_if (
		.clk        (clk),
		.rst_n      (rst_n),
		.sck        (sck),
		.cs_n       (cs_n),
		.dq_in      (dq_in),
		.dq_out     (dq_out),
		.dq_oe      (dq_oe),
		.insn_valid (insn_valid),
		.insn       (insn),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.rd_mode    (rd_mode),
		.rd_ready   (rd_ready),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

	qspi_scratch_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.insn_valid (insn_valid),
		.insn       (insn),
		.rd_mode    (rd_mode),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.rd_ready   (rd_ready),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

endmodule

// File: verilog/qspi_scratch_regs.sv
`timescale 1ns/10ps

module qspi_scratch_regs (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            insn_valid,
	input  qspi_pkg::byte_t insn,
	output logic            rd_mode,		// Combinational from the opcode
	input  logic            wr_valid,
	input  qspi_pkg::byte_t wr_data,
	input  logic            rd_ready,
	output logic            rd_valid,		// One cycle after rd_ready
	output qspi_pkg::byte_t rd_data
);

	import qspi_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Instruction decode

	opcode_t   opcode;
	reg_addr_t start_addr;

	assign opcode     = insn[7:4];
	assign start_addr = insn[3:0];

	// Only a read turns the bus around toward the host
	assign rd_mode = (opcode == OP_READ);

	//////////////////////////////////////////////////////////////////////
	// Pointer and write enable

	reg_addr_t ptr;			// Next byte to access
	reg_addr_t rd_addr;
	logic      wr_en;		// Current transaction is a write

	// First read lands in the same cycle as insn_valid
	assign rd_addr = insn_valid ? start_addr : ptr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr   <= '0;
			wr_en <= 1'b0;
		end else if (insn_valid) begin
			wr_en <= (opcode == OP_WRITE);
			// A read consumes the start byte right away
			if (rd_mode)
				ptr <= reg_addr_t'((start_addr + 1) % REG_DEPTH);
			else
				ptr <= start_addr;
		end else if (wr_valid && wr_en) begin
			ptr <= reg_addr_t'((ptr + 1) % REG_DEPTH);	// Wrap at bank end
		end else if (rd_ready) begin
			ptr <= reg_addr_t'((ptr + 1) % REG_DEPTH);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Byte bank

	byte_t bank [REG_DEPTH];

	// Unknown opcodes leave wr_en low, data is dropped
	always_ff @(posedge clk) begin
		if (wr_valid && wr_en)
			bank[ptr] <= wr_data;
	end

	// Every request is answered on the next cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end else begin
			rd_valid <= rd_ready;
			if (rd_ready)
				rd_data <= bank[rd_addr];
		end
	end

endmodule

// File: verilog/qspi_device_if.sv
`timescale 1ns/10ps

module qspi_device_if (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             sck,
	input  logic             cs_n,
	input  qspi_pkg::nibble_t dq_in,
	output qspi_pkg::nibble_t dq_out,
	output qspi_pkg::nibble_t dq_oe,
	output logic             insn_valid,	// One cycle, insn is complete
	output qspi_pkg::byte_t  insn,
	output logic             wr_valid,	// One cycle, wr_data is complete
	output qspi_pkg::byte_t  wr_data,
	input  logic             rd_mode,	// Valid with insn_valid
	output logic             rd_ready,	// Request for the next read byte
	input  logic             rd_valid,	// One cycle after rd_ready
	input  qspi_pkg::byte_t  rd_data
);

	import qspi_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Pin synchronizers

	logic    sck_sync;
	logic    cs_n_sync;
	nibble_t dq_sync;

	sync_3stage #(.RST_VAL(1'b0)) u_sync_sck (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (sck),
		.dout  (sck_sync)
	);

	// Chip select idles high
	sync_3stage #(.RST_VAL(1'b1)) u_sync_cs_n (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (cs_n),
		.dout  (cs_n_sync)
	);

	for (genvar i = 0; i < 4; i++) begin : g_dq_sync
		sync_3stage #(.RST_VAL(1'b0)) u_sync_dq (
			.clk   (clk),
			.rst_n (rst_n),
			.din   (dq_in[i]),
			.dout  (dq_sync[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Edge detection

	logic sck_ff;		// SCK one cycle back
	logic cs_n_ff;		// CS# one cycle back
	logic start;		// Registered CS# fall
	logic sck_rising;
	logic sck_falling;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_ff  <= 1'b0;
			cs_n_ff <= 1'b1;
			start   <= 1'b0;
		end else begin
			sck_ff  <= sck_sync;
			cs_n_ff <= cs_n_sync;
			start   <= !cs_n_sync && cs_n_ff;
		end
	end

	assign sck_rising  = sck_sync && !sck_ff;
	assign sck_falling = !sck_sync && sck_ff;

	//////////////////////////////////////////////////////////////////////
	// Read data holding and request

	qspi_state_t state;
	logic [1:0]  insn_count;		// Instruction beats taken so far
	nibble_t     dq_in_ff;		// Nibble of the previous rising edge
	logic        rd_sel;		// rd_mode captured at insn_valid
	byte_t       rd_data_next;		// Last byte from the bank
	byte_t       rd_data_fwd;

	// Bypass so a byte arriving this cycle is usable at once
	assign rd_data_fwd = rd_valid ? rd_data : rd_data_next;

	// First byte with the instruction, then one per low nibble sent
	assign rd_ready = insn_valid || ((state == RD_LO) && sck_falling);

	//////////////////////////////////////////////////////////////////////
	// Main state machine

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= DESELECTED;
			insn_count   <= '0;
			insn         <= '0;
			insn_valid   <= 1'b0;
			wr_valid     <= 1'b0;
			wr_data      <= '0;
			dq_in_ff     <= '0;
			dq_out       <= '0;
			dq_oe        <= '0;		// Bus released out of reset
			rd_sel       <= 1'b0;
			rd_data_next <= '0;
		end else begin
			insn_valid   <= 1'b0;		// Strobes default low
			wr_valid     <= 1'b0;
			rd_data_next <= rd_data_fwd;

			if (insn_valid)
				rd_sel <= rd_mode;

			// Turnaround picks the data direction
			if (state == TURNAROUND) begin
				if (rd_sel && sck_falling) begin
					dq_oe  <= 4'hf;				// Take the bus
					dq_out <= rd_data_fwd[7:4];	// High nibble first
					state  <= RD_LO;
				end else if (!rd_sel && sck_rising) begin
					state <= WR_HI;				// Dummy edge 3
				end
			end

			// Read nibbles change on falling edges
			if (sck_falling) begin
				case (state)
					RD_HI: begin
						dq_out <= rd_data_fwd[7:4];
						state  <= RD_LO;
					end
					RD_LO: begin
						dq_out <= rd_data_fwd[3:0];	// Byte done, next one requested
						state  <= RD_HI;
					end
					default: ;
				endcase
			end

			// Host data is sampled on rising edges
			if (sck_rising) begin
				dq_in_ff <= dq_sync;
				case (state)
					INSN: begin
						insn       <= {insn[3:0], dq_sync};
						insn_count <= insn_count + 2'd1;
						if (insn_count == 2'(INSN_NIBBLES - 1)) begin
							insn_valid <= 1'b1;
							state      <= TURNAROUND;
						end
					end
					WR_HI: state <= WR_LO;		// High nibble kept in dq_in_ff
					WR_LO: begin
						wr_valid <= 1'b1;
						wr_data  <= {dq_in_ff, dq_sync};
						state    <= WR_HI;
					end
					default: ;
				endcase
			end

			// Deselect wins over everything above
			if (cs_n_sync) begin
				state <= DESELECTED;
				dq_oe <= '0;
			end

			// New transaction
			if (start) begin
				state      <= INSN;
				insn_count <= '0;
				insn       <= '0;
				rd_sel     <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/sync_3stage.sv
`timescale 1ns/10ps

module sync_3stage #(
	parameter logic RST_VAL = 1'b0	// Idle level of the pin
) (
	input  logic clk,
	input  logic rst_n,
	input  logic din,		// Asynchronous pin
	output logic dout		// Safe to use in the clk domain
);

	// Stage 0 may go metastable, stages 1 and 2 let it settle
	logic [2:0] sync_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= {3{RST_VAL}};			// Start at the idle level
		end else begin
			sync_q <= {sync_q[1:0], din};	// Shift toward the output
		end
	end

	// Three clk cycles from pin to output
	assign dout = sync_q[2];

endmodule

// File: verilog/qspi_pkg.sv
package qspi_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and data widths

	typedef logic [3:0] nibble_t;		// One x4 bus beat
	typedef logic [7:0] byte_t;		// Data byte, two beats
	typedef logic [3:0] reg_addr_t;		// Scratch bank index
	typedef logic [3:0] opcode_t;		// Upper instruction nibble

	//////////////////////////////////////////////////////////////////////
	// Protocol constants

	// Instruction is one byte, high nibble first
	localparam int INSN_NIBBLES = 2;

	localparam opcode_t OP_READ  = 4'h1;	// Target drives data
	localparam opcode_t OP_WRITE = 4'h2;	// Host drives data

	// Scratch bank size, pointer wraps here
	localparam int REG_DEPTH = 16;

	//////////////////////////////////////////////////////////////////////
	// Transceiver state machine

	typedef enum logic [2:0] {
		DESELECTED = 3'd0,	// CS# high, bus released
		INSN       = 3'd1,	// Shifting in instruction nibbles
		TURNAROUND = 3'd2,	// One dummy beat before data
		WR_HI      = 3'd3,	// Next rising edge carries high nibble
		WR_LO      = 3'd4,	// Next rising edge completes the byte
		RD_HI      = 3'd5,	// Next falling edge drives high nibble
		RD_LO      = 3'd6	// Next falling edge drives low nibble
	} qspi_state_t;

	// Unused encoding 3'd7 falls into the default arms

endpackage
